// File: hw/cache_geom_pkg.sv
package cache_geom_pkg;

	// byte address from the cpu
	localparam int addr_w = 27;

	// one cpu data word
	localparam int word_w = 32;

	// four words make one line
	localparam int words_per_line = 4;
	localparam int offset_w = 2;

	// byte lane bits, never decoded, words only
	localparam int byte_off_w = 2;

	// 1024 lines, direct mapped
	localparam int index_w = 10;

	// what is left of the address above index and offset
	localparam int tag_w = addr_w - index_w - offset_w - byte_off_w;

	// full line as stored and moved on the memory bus
	localparam int line_w = words_per_line * word_w;

	// flat view for the memory bus, word view for select and merge
	// words[0] sits in the low 32 bits
	typedef union packed {
		logic [line_w-1:0] flat;
		logic [words_per_line-1:0][word_w-1:0] words;
	} line_t;

endpackage

// File: hw/bus_pkg.sv
package bus_pkg;

	// memory bus moves whole lines
	// address drops the low four byte bits of a line
	localparam int mem_adr_w = 23;
	localparam int mem_dat_w = 128;

	// cpu side FSM in the front end
	localparam int fe_state_w = 2;
	localparam logic [fe_state_w-1:0] fe_idle = 2'd0;
	localparam logic [fe_state_w-1:0] fe_lookup = 2'd1;
	localparam logic [fe_state_w-1:0] fe_check = 2'd2;
	localparam logic [fe_state_w-1:0] fe_wait = 2'd3;

	// memory side FSM in the port engine
	localparam int mp_state_w = 2;
	localparam logic [mp_state_w-1:0] mp_idle = 2'd0;
	localparam logic [mp_state_w-1:0] mp_write = 2'd1;
	localparam logic [mp_state_w-1:0] mp_turn = 2'd2;
	localparam logic [mp_state_w-1:0] mp_read = 2'd3;

endpackage

// File: hw/line_store.sv
module line_store (
	input  logic clk,
	input  logic rstn,

	// read side, result one cycle later
	input  logic [cache_geom_pkg::index_w-1:0] rd_index,
	output logic [cache_geom_pkg::tag_w-1:0] rd_tag,
	output logic rd_valid,
	output logic rd_dirty,
	output cache_geom_pkg::line_t rd_line,

	// write side, takes effect at the edge
	input  logic wr_en,
	input  logic [cache_geom_pkg::index_w-1:0] wr_index,
	input  logic [cache_geom_pkg::tag_w-1:0] wr_tag,
	input  cache_geom_pkg::line_t wr_line,
	input  logic wr_dirty
);
	import cache_geom_pkg::*;

	// line data and tags, block ram style
	logic [line_w-1:0] line_mem [0:2**index_w-1];
	logic [tag_w-1:0] tag_mem [0:2**index_w-1];

	// status bits kept in flops so reset can clear them
	logic [2**index_w-1:0] valid_bits;
	logic [2**index_w-1:0] dirty_bits;

	// ram write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			line_mem[wr_index] <= wr_line.flat;
			tag_mem[wr_index] <= wr_tag;
		end
	end

	// registered ram read
	// same index written in the same cycle gives the old content
	always_ff @(posedge clk) begin
		rd_line.flat <= line_mem[rd_index];
		rd_tag <= tag_mem[rd_index];
	end

	// status update
	// a write always makes the line valid
	always_ff @(posedge clk) begin
		if (!rstn) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en) begin
			valid_bits[wr_index] <= 1'b1;
			dirty_bits[wr_index] <= wr_dirty;
		end
	end

	// status read, aligned with the ram read
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_valid <= 1'b0;
			rd_dirty <= 1'b0;
		end else begin
			rd_valid <= valid_bits[rd_index];
			rd_dirty <= dirty_bits[rd_index];
		end
	end

endmodule

// File: hw/cache_frontend.sv
module cache_frontend (
	input  logic clk,
	input  logic rstn,

	// cpu wishbone slave
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [cache_geom_pkg::addr_w-1:0] adr,
	input  logic [cache_geom_pkg::word_w-1:0] dat_w,
	output logic [cache_geom_pkg::word_w-1:0] dat_r,
	output logic ack,

	// line store
	output logic [cache_geom_pkg::index_w-1:0] rd_index,
	input  logic [cache_geom_pkg::tag_w-1:0] rd_tag,
	input  logic rd_valid,
	input  logic rd_dirty,
	input  cache_geom_pkg::line_t rd_line,
	output logic wr_en,
	output logic [cache_geom_pkg::index_w-1:0] wr_index,
	output logic [cache_geom_pkg::tag_w-1:0] wr_tag,
	output cache_geom_pkg::line_t wr_line,
	output logic wr_dirty,

	// miss jobs to the memory port
	output logic job_start,
	output logic job_evict,
	output logic [bus_pkg::mem_adr_w-1:0] evict_adr,
	output logic [cache_geom_pkg::line_w-1:0] evict_line,
	output logic [bus_pkg::mem_adr_w-1:0] fill_adr,
	input  logic job_done,
	input  logic [cache_geom_pkg::line_w-1:0] fill_line
);
	import cache_geom_pkg::*;
	import bus_pkg::*;

	logic [fe_state_w-1:0] state;
	logic [tag_w-1:0] req_tag;
	logic [index_w-1:0] req_index;
	logic [offset_w-1:0] req_word;
	logic hit;
	line_t merged;

	// address split, master holds adr until ack
	assign req_tag = adr[addr_w-1 -: tag_w];
	assign req_index = adr[byte_off_w + offset_w +: index_w];
	assign req_word = adr[byte_off_w +: offset_w];

	// store output belongs to adr once in fe_check
	assign hit = rd_valid && (rd_tag == req_tag);

	assign rd_index = req_index;
	assign wr_index = req_index;
	assign wr_tag = req_tag;

	// stored line with the cpu word dropped in
	always_comb begin
		merged = rd_line;
		merged.words[req_word] = dat_w;
	end

	// two writers into the store
	// write hit marks dirty, fill goes in clean
	always_comb begin
		wr_en = 1'b0;
		wr_line = merged;
		wr_dirty = 1'b1;
		if (state == fe_check && hit && we) begin
			wr_en = 1'b1;
		end else if (state == fe_wait && job_done) begin
			wr_en = 1'b1;
			wr_line.flat = fill_line;
			wr_dirty = 1'b0;
		end
	end

	// request sequencing
	// idle -> lookup (store read) -> check -> ack or job
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= fe_idle;
			ack <= 1'b0;
			job_start <= 1'b0;
		end else begin
			ack <= 1'b0;
			job_start <= 1'b0;
			case (state)
				fe_idle: begin
					// stb still high in the ack cycle, skip it
					if (cyc && stb && !ack) begin
						state <= fe_lookup;
					end
				end
				fe_lookup: begin
					state <= fe_check;
				end
				fe_check: begin
					if (hit) begin
						ack <= 1'b1;
						state <= fe_idle;
					end else begin
						job_start <= 1'b1;
						state <= fe_wait;
					end
				end
				default: begin
					// fill installed this cycle, look again
					if (job_done) begin
						state <= fe_lookup;
					end
				end
			endcase
		end
	end

	// read data and job payload, only fe_check loads them
	always_ff @(posedge clk) begin
		if (state == fe_check) begin
			dat_r <= rd_line.words[req_word];
			job_evict <= rd_valid && rd_dirty;
			// victim line address from its own tag
			evict_adr <= {rd_tag, req_index};
			evict_line <= rd_line.flat;
			fill_adr <= adr[addr_w-1 : byte_off_w + offset_w];
		end
	end

endmodule

// File: hw/mem_port.sv
module mem_port (
	input  logic clk,
	input  logic rstn,

	// job from the front end
	input  logic job_start,
	input  logic job_evict,
	input  logic [bus_pkg::mem_adr_w-1:0] evict_adr,
	input  logic [bus_pkg::mem_dat_w-1:0] evict_line,
	input  logic [bus_pkg::mem_adr_w-1:0] fill_adr,
	output logic job_done,
	output logic [bus_pkg::mem_dat_w-1:0] fill_line,

	// wishbone master, one line per transfer
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [bus_pkg::mem_adr_w-1:0] mem_adr,
	output logic [bus_pkg::mem_dat_w-1:0] mem_dat_w,
	input  logic [bus_pkg::mem_dat_w-1:0] mem_dat_r,
	input  logic mem_ack
);
	import bus_pkg::*;

	logic [mp_state_w-1:0] state;

	// bus control
	// eviction first, then one idle cycle, then the fill read
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= mp_idle;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
			mem_we <= 1'b0;
			job_done <= 1'b0;
		end else begin
			job_done <= 1'b0;
			case (state)
				mp_idle: begin
					if (job_start) begin
						mem_cyc <= 1'b1;
						mem_stb <= 1'b1;
						mem_we <= job_evict;
						state <= job_evict ? mp_write : mp_read;
					end
				end
				mp_write: begin
					// hold everything until the slave acks
					if (mem_ack) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						mem_we <= 1'b0;
						state <= mp_turn;
					end
				end
				mp_turn: begin
					// cyc was low for one cycle, start the read
					mem_cyc <= 1'b1;
					mem_stb <= 1'b1;
					state <= mp_read;
				end
				default: begin
					if (mem_ack) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						job_done <= 1'b1;
						state <= mp_idle;
					end
				end
			endcase
		end
	end

	// address and data
	// loaded only when a cycle opens, stable through the wait
	always_ff @(posedge clk) begin
		if (state == mp_idle && job_start) begin
			mem_adr <= job_evict ? evict_adr : fill_adr;
			mem_dat_w <= evict_line;
		end else if (state == mp_turn) begin
			mem_adr <= fill_adr;
		end
		// fill line sampled with the read ack
		if (state == mp_read && mem_ack) begin
			fill_line <= mem_dat_r;
		end
	end

endmodule

// File: hw/cache_top.sv
module cache_top (
	input  logic clk,
	input  logic rstn,

	// cpu wishbone slave
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [cache_geom_pkg::addr_w-1:0] adr,
	input  logic [cache_geom_pkg::word_w-1:0] dat_w,
	output logic [cache_geom_pkg::word_w-1:0] dat_r,
	output logic ack,

	// memory wishbone master
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [bus_pkg::mem_adr_w-1:0] mem_adr,
	output logic [bus_pkg::mem_dat_w-1:0] mem_dat_w,
	input  logic [bus_pkg::mem_dat_w-1:0] mem_dat_r,
	input  logic mem_ack
);
	import cache_geom_pkg::*;
	import bus_pkg::*;

	// front end <-> line store
	logic [index_w-1:0] rd_index;
	logic [tag_w-1:0] rd_tag;
	logic rd_valid;
	logic rd_dirty;
	line_t rd_line;
	logic wr_en;
	logic [index_w-1:0] wr_index;
	logic [tag_w-1:0] wr_tag;
	line_t wr_line;
	logic wr_dirty;

	// front end <-> memory port
	logic job_start;
	logic job_evict;
	logic job_done;
	logic [mem_adr_w-1:0] evict_adr;
	logic [mem_adr_w-1:0] fill_adr;
	logic [line_w-1:0] evict_line;
	logic [line_w-1:0] fill_line;

	cache_frontend frontend_i (
		.clk, .rstn, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
		.rd_index, .rd_tag, .rd_valid, .rd_dirty, .rd_line,
		.wr_en, .wr_index, .wr_tag, .wr_line, .wr_dirty,
		.job_start, .job_evict, .evict_adr, .evict_line, .fill_adr,
		.job_done, .fill_line
	);

	line_store store_i (
		.clk, .rstn, .rd_index, .rd_tag, .rd_valid, .rd_dirty, .rd_line,
		.wr_en, .wr_index, .wr_tag, .wr_line, .wr_dirty
	);

	mem_port mem_port_i (
		.clk, .rstn, .job_start, .job_evict, .evict_adr, .evict_line, .fill_adr,
		.job_done, .fill_line,
		.mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack
	);

endmodule

// File: tests/cache_checker.sv
module cache_checker (
	input  logic clk,
	input  logic rstn,
	input  logic cyc,
	input  logic stb,
	input  logic ack,
	input  logic mem_cyc,
	input  logic mem_stb,
	input  logic mem_we,
	input  logic [bus_pkg::mem_adr_w-1:0] mem_adr,
	input  logic [bus_pkg::mem_dat_w-1:0] mem_dat_w,
	input  logic mem_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far
	int fail_count = 0;

	// cpu slave acks only a live request
	ack_with_request: assert property (@(posedge clk) disable iff (!rstn) ack |-> cyc && stb)
	else begin
		fail_count++;
		$error("ack without cyc and stb");
	end

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
	else begin
		fail_count++;
		$error("ack held longer than one cycle");
	end

	// memory request frozen while the slave has not acked
	mem_req_stable: assert property (@(posedge clk) disable iff (!rstn)
		mem_stb && !mem_ack |=> $stable(mem_cyc) && $stable(mem_stb) && $stable(mem_we)
			&& $stable(mem_adr) && $stable(mem_dat_w))
	else begin
		fail_count++;
		$error("memory request changed before mem_ack");
	end

	// no bus cycle out of reset
	mem_idle_in_reset: assert property (@(posedge clk) !rstn |=> !mem_cyc)
	else begin
		fail_count++;
		$error("mem_cyc high during reset");
	end

endmodule

bind cache_top cache_checker checker_i (
	.clk, .rstn, .cyc, .stb, .ack,
	.mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_ack
);

// File: tests/cache_monitor.sv
module cache_monitor (
	input  logic clk,
	input  logic rstn,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [cache_geom_pkg::addr_w-1:0] adr,
	input  logic [cache_geom_pkg::word_w-1:0] dat_w,
	input  logic [cache_geom_pkg::word_w-1:0] dat_r,
	input  logic ack,
	input  logic mem_cyc,
	input  logic mem_stb,
	input  logic mem_we,
	input  logic [bus_pkg::mem_adr_w-1:0] mem_adr,
	input  logic [bus_pkg::mem_dat_w-1:0] mem_dat_w,
	input  logic mem_ack
);
	timeunit 1ns;
	timeprecision 1ps;
	import cache_geom_pkg::*;
	import bus_pkg::*;

	// shadow of every word the cpu wrote, keyed by word address
	logic [word_w-1:0] shadow [int unsigned];
	int data_checks = 0;
	int data_errors = 0;
	int other_checks = 0;
	int other_errors = 0;
	// memory bus traffic, plus the counts at the last traffic check
	int mem_reads = 0;
	int mem_writes = 0;
	int reads_seen = 0;
	int writes_seen = 0;
	logic [mem_adr_w-1:0] last_wr_adr = '0;
	line_t last_wr_line = '0;
	logic [word_w-1:0] exp_word;

	function automatic int unsigned word_key(logic [addr_w-1:0] a);
		return 32'(a[addr_w-1:byte_off_w]);
	endfunction

	// reference model: last written value, else the word's address inverted
	function automatic logic [word_w-1:0] expected_word(logic [addr_w-1:0] a);
		if (shadow.exists(word_key(a))) begin
			return shadow[word_key(a)];
		end
		return ~word_w'({a[addr_w-1:byte_off_w], {byte_off_w{1'b0}}});
	endfunction

	// cpu responses and memory transfers, sampled at the edge
	always @(posedge clk) begin
		if (rstn) begin
			if (ack && !(cyc && stb)) begin
				data_errors++;
				$display("ack came while no request was pending, adr %h", adr);
			end else if (ack && we) begin
				shadow[word_key(adr)] = dat_w;
			end else if (ack) begin
				exp_word = expected_word(adr);
				data_checks++;
				if (dat_r !== exp_word) begin
					data_errors++;
					$display("Mismatch dat_r at adr %h: got %h expected %h", adr, dat_r, exp_word);
				end
			end
			// a memory cycle only ever serves a cpu miss
			if (mem_cyc && !cyc) begin
				data_errors++;
				$display("memory cycle open with no cpu request");
			end
			if (mem_cyc && mem_stb && mem_ack && mem_we) begin
				mem_writes++;
				last_wr_adr = mem_adr;
				last_wr_line.flat = mem_dat_w;
			end else if (mem_cyc && mem_stb && mem_ack) begin
				mem_reads++;
			end
		end
	end

	// memory cycles since the previous call
	task automatic check_traffic(input int exp_reads, input int exp_writes);
		other_checks++;
		if (mem_reads - reads_seen != exp_reads) begin
			other_errors++;
			$display("Mismatch mem read cycles: got %h expected %h",
				mem_reads - reads_seen, exp_reads);
		end
		if (mem_writes - writes_seen != exp_writes) begin
			other_errors++;
			$display("Mismatch mem write cycles: got %h expected %h",
				mem_writes - writes_seen, exp_writes);
		end
		reads_seen = mem_reads;
		writes_seen = mem_writes;
	endtask

	// last evicted line against the reference, word by word
	task automatic check_last_write(input logic [mem_adr_w-1:0] line_adr);
		logic [word_w-1:0] want;
		other_checks++;
		if (last_wr_adr !== line_adr) begin
			other_errors++;
			$display("Mismatch mem_adr: got %h expected %h", last_wr_adr, line_adr);
		end
		for (int k = 0; k < words_per_line; k++) begin
			want = expected_word({line_adr, offset_w'(k), {byte_off_w{1'b0}}});
			if (last_wr_line.words[k] !== want) begin
				other_errors++;
				$display("Mismatch mem_dat_w word %0d: got %h expected %h",
					k, last_wr_line.words[k], want);
			end
		end
	endtask

	function automatic int total_errors();
		return data_errors + other_errors;
	endfunction

	function automatic int total_checks();
		return data_checks + other_checks;
	endfunction

endmodule

// File: tests/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cache_geom_pkg::*;
	import bus_pkg::*;

	localparam int rand_ops = 400;
	// 18 directed accesses in tests 1 to 5 plus the random ones
	localparam int n_ops = 18 + rand_ops;
	// budget of 40 cycles per access plus margin for reset
	localparam int max_cycles = n_ops * 40 + 200;

	logic clk = 1'b0;
	logic rstn = 1'b0;
	logic cyc = 1'b0;
	logic stb = 1'b0;
	logic we = 1'b0;
	logic [addr_w-1:0] adr = '0;
	logic [word_w-1:0] dat_w = '0;
	logic [word_w-1:0] dat_r;
	logic ack;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [mem_adr_w-1:0] mem_adr;
	logic [line_w-1:0] mem_dat_w;
	logic [line_w-1:0] mem_dat_r = '0;
	logic mem_ack = 1'b0;

	// written-back lines by line address
	logic [line_w-1:0] main_mem [int unsigned];
	logic mem_busy = 1'b0;
	int mem_delay = 0;
	int cycle_count = 0;
	int errors_before = 0;

	cache_top dut_i (.*);

	cache_monitor monitor_i (.*);

	always #5 clk = ~clk;

	// untouched lines hold each word's byte address inverted
	function automatic logic [line_w-1:0] read_line(logic [mem_adr_w-1:0] la);
		line_t l;
		if (main_mem.exists(32'(la))) begin
			return main_mem[32'(la)];
		end
		for (int k = 0; k < words_per_line; k++) begin
			l.words[k] = ~{5'b0, la, offset_w'(k), {byte_off_w{1'b0}}};
		end
		return l.flat;
	endfunction

	// main memory slave answers 1 to 4 cycles after the request
	always @(posedge clk) begin
		if (!rstn) begin
			mem_ack <= 1'b0;
			mem_busy <= 1'b0;
		end else if (mem_ack) begin
			// cache closes the cycle now
			mem_ack <= 1'b0;
		end else if (mem_cyc && mem_stb && !mem_busy) begin
			mem_busy <= 1'b1;
			mem_delay <= int'($urandom_range(1, 4));
		end else if (mem_cyc && mem_stb && mem_delay == 1) begin
			mem_busy <= 1'b0;
			mem_ack <= 1'b1;
			if (mem_we) begin
				main_mem[32'(mem_adr)] = mem_dat_w;
			end
			mem_dat_r <= read_line(mem_adr);
		end else if (mem_cyc && mem_stb) begin
			mem_delay <= mem_delay - 1;
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("run timed out after %0d cycles before all tests finished", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [addr_w-1:0] make_addr(logic [tag_w-1:0] t,
		logic [index_w-1:0] i, logic [offset_w-1:0] w);
		return {t, i, w, {byte_off_w{1'b0}}};
	endfunction

	// monitor findings plus failed bus assertions
	function automatic int error_total();
		return monitor_i.total_errors() + dut_i.checker_i.fail_count;
	endfunction

	// one wishbone classic access held until ack is sampled
	task automatic cpu_access(input logic is_write, input logic [addr_w-1:0] a,
		input logic [word_w-1:0] d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= is_write;
		adr <= a;
		dat_w <= d;
		do begin
			@(posedge clk);
		end while (!ack);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic read_all_words(input logic [tag_w-1:0] t, input logic [index_w-1:0] i);
		for (int w = 0; w < words_per_line; w++) begin
			cpu_access(1'b0, make_addr(t, i, offset_w'(w)), '0);
		end
	endtask

	// one line per finished test
	task automatic report_test(input string name);
		int errs;
		@(posedge clk);
		errs = error_total();
		if (errs == errors_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d new errors", name, errs - errors_before);
		end
		errors_before = errs;
	endtask

	initial begin
		logic [addr_w-1:0] a;
		void'($urandom(89));
		repeat (3) @(posedge clk);
		rstn <= 1'b1;

		// idle bus then a cold read
		repeat (5) @(posedge clk);
		monitor_i.check_traffic(0, 0);
		cpu_access(1'b0, make_addr(13'd1, 10'd5, 2'd0), '0);
		monitor_i.check_traffic(1, 0);
		report_test("test 1 reset and first read");

		// whole line now cached
		read_all_words(13'd1, 10'd5);
		monitor_i.check_traffic(0, 0);
		report_test("test 2 read hits");

		cpu_access(1'b1, make_addr(13'd1, 10'd5, 2'd2), 32'h5a5a_0302);
		read_all_words(13'd1, 10'd5);
		monitor_i.check_traffic(0, 0);
		report_test("test 3 write hit");

		// same index with another tag sends the dirty line out first
		cpu_access(1'b1, make_addr(13'd1, 10'd5, 2'd1), 32'hc0de_0401);
		monitor_i.check_traffic(0, 0);
		cpu_access(1'b0, make_addr(13'd2, 10'd5, 2'd0), '0);
		monitor_i.check_traffic(1, 1);
		monitor_i.check_last_write({13'd1, 10'd5});
		cpu_access(1'b0, make_addr(13'd1, 10'd5, 2'd1), '0);
		monitor_i.check_traffic(1, 0);
		report_test("test 4 dirty eviction");

		// write allocate fetches the rest of the line
		cpu_access(1'b1, make_addr(13'd3, 10'd9, 2'd3), 32'hfeed_0503);
		monitor_i.check_traffic(1, 0);
		read_all_words(13'd3, 10'd9);
		monitor_i.check_traffic(0, 0);
		report_test("test 5 write miss");

		// tags 4..6 over indexes 20..23 for many conflicts
		for (int n = 0; n < rand_ops; n++) begin
			a = make_addr(tag_w'(4 + $urandom_range(0, 2)),
				index_w'(20 + $urandom_range(0, 3)),
				offset_w'($urandom_range(0, 3)));
			cpu_access($urandom_range(0, 1) == 1, a, $urandom());
		end
		report_test("test 6 random traffic");

		$display("%0d checks, %0d errors", monitor_i.total_checks(), error_total());
		if (error_total() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim.f
hw/cache_geom_pkg.sv
hw/bus_pkg.sv
hw/line_store.sv
hw/cache_frontend.sv
hw/mem_port.sv
hw/cache_top.sv
tests/cache_checker.sv
tests/cache_monitor.sv
tests/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
